//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= mod_tb
FILELIST  ?= mod_mult.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Finished with no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then echo "PASS"; else echo "FAIL"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- logic/delay_line.sv
`timescale 1ns/1ps
`default_nettype none

module delay_line #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 1
) (
  input  wire              CLK,
  input  wire              rst_n,
  input  wire  [WIDTH-1:0] din,
  output logic [WIDTH-1:0] dout
);

  logic [WIDTH-1:0] stage [DEPTH];

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage[i] <= '0;
      end
    end else begin
      stage[0] <= din;
      for (int i = 1; i < DEPTH; i++) begin
        stage[i] <= stage[i-1];  // shift toward dout.
      end
    end
  end

  assign dout = stage[DEPTH-1];

  a_depth_min: assert property (@(posedge CLK) DEPTH >= 1)
    else $error("delay_line needs at least one stage.");

endmodule

`default_nettype wire

//--- logic/mod_mem.sv
`timescale 1ns/1ps
`default_nettype none

module mod_mem (
  input  wire                        CLK,
  input  wire                        rst_n,
  input  wire                        wr_en,
  input  wire  [mod_pkg::ADDR_W-1:0] wr_addr,
  input  mod_pkg::mod_wdata_u        wr_data,
  input  wire  [mod_pkg::IDX_W-1:0]  rd_idx,
  input  wire                        rd_seg,
  output logic [mod_pkg::MOD_W-1:0]  rd_sample
);

  import mod_pkg::*;

  // even and odd samples live in separate banks so a pair lands in one write.
  localparam int SEG_W   = $clog2(SEG_N);
  localparam int BANK_AW = SEG_W + IDX_W - 1;

  logic [MOD_W-1:0]   mem_even [2**BANK_AW];
  logic [MOD_W-1:0]   mem_odd  [2**BANK_AW];

  logic               mem_wr;
  logic [BANK_AW-1:0] wr_pair;
  logic [IDX_W-1:0]   rd_idx_q;
  logic               rd_seg_q;
  logic [BANK_AW-1:0] rd_pair;

  assign mem_wr  = wr_en && !wr_addr[CTL_BIT];
  assign wr_pair = {wr_addr[IDX_W-1], wr_addr[IDX_W-2:0]};  // segment, pair index.

  always_ff @(posedge CLK) begin
    if (mem_wr) begin
      mem_even[wr_pair] <= wr_data.samples.lo;
      mem_odd[wr_pair]  <= wr_data.samples.hi;
    end
  end

  // first read stage, address register.
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      rd_idx_q <= '0;
      rd_seg_q <= 1'b0;
    end else begin
      rd_idx_q <= rd_idx;
      rd_seg_q <= rd_seg;
    end
  end

  assign rd_pair = {rd_seg_q, rd_idx_q[IDX_W-1:1]};

  // second read stage, array output register.
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      rd_sample <= '0;
    end else if (rd_idx_q[0]) begin
      rd_sample <= mem_odd[rd_pair];
    end else begin
      rd_sample <= mem_even[rd_pair];
    end
  end

  a_sample_known: assert property (
    @(posedge CLK) disable iff (!rst_n) !$isunknown(rd_sample)
  ) else $error("rd_sample unknown, table entry never written.");

endmodule

`default_nettype wire

//--- logic/mod_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module mod_multiplier (
  input  wire                       CLK,
  input  wire                       rst_n,
  input  wire                       din_valid,
  input  wire  [mod_pkg::INT_W-1:0] intensity_in,
  input  wire  [mod_pkg::IDX_W-1:0] seg_idx0,
  input  wire  [mod_pkg::IDX_W-1:0] seg_idx1,
  input  wire                       seg_sel,
  input  wire                       stop,
  input  wire  [mod_pkg::MOD_W-1:0] rd_sample,
  output logic [mod_pkg::IDX_W-1:0] rd_idx,
  output logic                      rd_seg,
  output logic [mod_pkg::OUT_W-1:0] intensity_out,
  output logic                      dout_valid,
  output logic [mod_pkg::IDX_W-1:0] dbg_idx,
  output logic                      dbg_segment,
  output logic                      dbg_stop
);

  import mod_pkg::*;

  localparam int FILL_W = $clog2(MUL_LAT + 1);
  localparam int CNT_W  = $clog2(N_TRANS);

  typedef enum logic [1:0] {
    IDLE,
    WAIT_RD0,
    WAIT_RD1,
    RUN
  } state_e;

  state_e           state;
  logic [IDX_W-1:0] idx_q;
  logic             seg_q;
  logic             stop_q;
  logic [FILL_W-1:0] fill_cnt;
  logic [CNT_W-1:0] out_cnt;
  logic             valid_int;
  logic [INT_W-1:0] intensity_al;
  logic [INT_W-1:0] mul_a_q;
  logic [MOD_W-1:0] mul_b_q;
  logic [OUT_W-1:0] prod_q;

  // intensities wait for the sample to come back from memory.
  delay_line #(
    .WIDTH(INT_W),
    .DEPTH(INT_ALIGN)
  ) intensity_dly_i (
    .CLK  (CLK),
    .rst_n(rst_n),
    .din  (intensity_in),
    .dout (intensity_al)
  );

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state     <= IDLE;
      idx_q     <= '0;
      seg_q     <= 1'b0;
      stop_q    <= 1'b0;
      fill_cnt  <= '0;
      out_cnt   <= '0;
      valid_int <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          valid_int <= 1'b0;
          if (din_valid) begin
            fill_cnt <= '0;
            out_cnt  <= '0;
            stop_q   <= stop;
            if (!stop) begin  // stopped frames keep the old index.
              idx_q <= seg_sel ? seg_idx1 : seg_idx0;
              seg_q <= seg_sel;
            end
            state <= WAIT_RD0;
          end
        end
        WAIT_RD0: state <= WAIT_RD1;
        WAIT_RD1: state <= RUN;  // sample valid from here on.
        RUN: begin
          if (fill_cnt != FILL_W'(MUL_LAT - 1)) begin
            fill_cnt <= fill_cnt + 1'b1;
          end else begin
            valid_int <= 1'b1;
            out_cnt   <= out_cnt + 1'b1;
            if (out_cnt == CNT_W'(N_TRANS - 1)) begin
              state <= IDLE;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // two-stage multiply, operands then product.
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      mul_a_q <= '0;
      mul_b_q <= '0;
      prod_q  <= '0;
    end else begin
      mul_a_q <= intensity_al;
      mul_b_q <= rd_sample;
      prod_q  <= mul_a_q * mul_b_q;
    end
  end

  delay_line #(
    .WIDTH(OUT_W),
    .DEPTH(1)
  ) product_dly_i (
    .CLK  (CLK),
    .rst_n(rst_n),
    .din  (prod_q),
    .dout (intensity_out)
  );

  delay_line #(
    .WIDTH(1),
    .DEPTH(1)
  ) valid_dly_i (
    .CLK  (CLK),
    .rst_n(rst_n),
    .din  (valid_int),
    .dout (dout_valid)
  );

  assign rd_idx      = idx_q;
  assign rd_seg      = seg_q;
  assign dbg_idx     = idx_q;
  assign dbg_segment = seg_q;
  assign dbg_stop    = stop_q;

  a_frame_idle: assert property (
    @(posedge CLK) disable iff (!rst_n) din_valid |-> state == IDLE
  ) else $error("din_valid while a frame is still in flight.");

endmodule

`default_nettype wire

//--- logic/mod_pkg.sv
`default_nettype none

package mod_pkg;

  localparam int N_TRANS    = 249;  // intensities per frame.
  localparam int IDX_W      = 15;
  localparam int SEG_N      = 2;
  localparam int MOD_W      = 8;
  localparam int INT_W      = 8;
  localparam int OUT_W      = 16;
  localparam int ADDR_W     = 16;
  localparam int CTL_BIT    = 15;   // set selects cycle_last registers.
  localparam int MEM_RD_LAT = 2;    // index to sample.
  localparam int INT_ALIGN  = 3;    // intensity delay to meet the sample.
  localparam int MUL_LAT    = 2;

  // host write word, read as a sample pair by memory or as config by the timer.
  typedef union packed {
    struct packed {
      logic [MOD_W-1:0] hi;  // odd index.
      logic [MOD_W-1:0] lo;  // even index.
    } samples;
    struct packed {
      logic             rsvd;
      logic [IDX_W-1:0] cycle_last;
    } cfg;
  } mod_wdata_u;

endpackage

`default_nettype wire

//--- logic/mod_timer.sv
`timescale 1ns/1ps
`default_nettype none

module mod_timer (
  input  wire                        CLK,
  input  wire                        rst_n,
  input  wire                        wr_en,
  input  wire  [mod_pkg::ADDR_W-1:0] wr_addr,
  input  mod_pkg::mod_wdata_u        wr_data,
  input  wire                        update,
  output logic [mod_pkg::IDX_W-1:0]  seg_idx0,
  output logic [mod_pkg::IDX_W-1:0]  seg_idx1
);

  import mod_pkg::*;

  logic [IDX_W-1:0] cycle_last [SEG_N];
  logic [IDX_W-1:0] idx_q      [SEG_N];
  logic             cfg_wr;

  assign cfg_wr = wr_en && wr_addr[CTL_BIT];

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      for (int s = 0; s < SEG_N; s++) begin
        cycle_last[s] <= '1;  // full table length.
        idx_q[s]      <= '0;
      end
    end else begin
      for (int s = 0; s < SEG_N; s++) begin
        if (cfg_wr && int'(wr_addr[0]) == s) begin
          // a new length restarts the segment.
          cycle_last[s] <= wr_data.cfg.cycle_last;
          idx_q[s]      <= '0;
        end else if (update) begin
          if (idx_q[s] == cycle_last[s]) begin
            idx_q[s] <= '0;  // wrap.
          end else begin
            idx_q[s] <= idx_q[s] + 1'b1;
          end
        end
      end
    end
  end

  assign seg_idx0 = idx_q[0];
  assign seg_idx1 = idx_q[1];

  for (genvar g = 0; g < SEG_N; g++) begin : g_chk
    a_idx_bound: assert property (
      @(posedge CLK) disable iff (!rst_n) idx_q[g] <= cycle_last[g]
    ) else $error("segment %0d index past cycle_last.", g);
  end

endmodule

`default_nettype wire

//--- logic/mod_top.sv
`timescale 1ns/1ps
`default_nettype none

module mod_top (
  input  wire                        CLK,
  input  wire                        rst_n,
  input  wire                        wr_en,
  input  wire  [mod_pkg::ADDR_W-1:0] wr_addr,
  input  mod_pkg::mod_wdata_u        wr_data,
  input  wire                        update,
  input  wire                        din_valid,
  input  wire  [mod_pkg::INT_W-1:0]  intensity_in,
  input  wire                        seg_sel,
  input  wire                        stop,
  output logic [mod_pkg::OUT_W-1:0]  intensity_out,
  output logic                       dout_valid,
  output logic [mod_pkg::IDX_W-1:0]  dbg_idx,
  output logic                       dbg_segment,
  output logic                       dbg_stop
);

  import mod_pkg::*;

  logic [IDX_W-1:0] seg_idx0;
  logic [IDX_W-1:0] seg_idx1;
  logic [IDX_W-1:0] rd_idx;
  logic             rd_seg;
  logic [MOD_W-1:0] rd_sample;

  mod_timer timer_i (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .update  (update),
    .seg_idx0(seg_idx0),
    .seg_idx1(seg_idx1)
  );

  mod_mem mem_i (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_idx   (rd_idx),
    .rd_seg   (rd_seg),
    .rd_sample(rd_sample)
  );

  mod_multiplier mult_i (
    .CLK          (CLK),
    .rst_n        (rst_n),
    .din_valid    (din_valid),
    .intensity_in (intensity_in),
    .seg_idx0     (seg_idx0),
    .seg_idx1     (seg_idx1),
    .seg_sel      (seg_sel),
    .stop         (stop),
    .rd_sample    (rd_sample),
    .rd_idx       (rd_idx),
    .rd_seg       (rd_seg),
    .intensity_out(intensity_out),
    .dout_valid   (dout_valid),
    .dbg_idx      (dbg_idx),
    .dbg_segment  (dbg_segment),
    .dbg_stop     (dbg_stop)
  );

endmodule

`default_nettype wire

//--- mod_mult.f
logic/mod_pkg.sv
logic/delay_line.sv
logic/mod_mem.sv
logic/mod_timer.sv
logic/mod_multiplier.sv
logic/mod_top.sv
verif/mod_tb.sv

//--- verif/mod_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mod_tb;

  import mod_pkg::*;

  localparam int N_FRAMES = 8;
  localparam int TIMEOUT  = N_FRAMES * (N_TRANS + 20) + 2000;
  localparam int TBL_LEN  = 16;  // table entries written per segment.

  logic                CLK = 1'b0;
  logic                rst_n;
  logic                wr_en;
  logic [ADDR_W-1:0]   wr_addr;
  mod_wdata_u          wr_data;
  logic                update;
  logic                din_valid;
  logic [INT_W-1:0]    intensity_in;
  logic                seg_sel;
  logic                stop;
  logic [OUT_W-1:0]    intensity_out;
  logic                dout_valid;
  logic [IDX_W-1:0]    dbg_idx;
  logic                dbg_segment;
  logic                dbg_stop;

  // reference model state.
  logic [MOD_W-1:0]    tbl [SEG_N][TBL_LEN];
  int                  model_last [SEG_N];
  int                  model_idx [SEG_N];
  int                  cur_idx;
  int                  cur_seg;
  logic [OUT_W-1:0]    exp_q[$];
  logic [OUT_W-1:0]    exp_head;
  int                  exp_cnt;
  logic [IDX_W-1:0]    exp_idx;
  logic                exp_seg;
  logic                exp_stop;
  logic                frame_seen;
  int                  run_len;
  int                  cycles;
  integer              seed;

  mod_top dut_i (
    .CLK          (CLK),
    .rst_n        (rst_n),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .update       (update),
    .din_valid    (din_valid),
    .intensity_in (intensity_in),
    .seg_sel      (seg_sel),
    .stop         (stop),
    .intensity_out(intensity_out),
    .dout_valid   (dout_valid),
    .dbg_idx      (dbg_idx),
    .dbg_segment  (dbg_segment),
    .dbg_stop     (dbg_stop)
  );

  initial begin
    forever #5 CLK = ~CLK;
  end

  function automatic void refresh_head();
    exp_cnt  = exp_q.size();
    exp_head = (exp_cnt > 0) ? exp_q[0] : '0;
  endfunction

  task automatic write_pair(input int seg, input int pair);
    logic [MOD_W-1:0] lo;
    logic [MOD_W-1:0] hi;
    lo = MOD_W'($random(seed));
    hi = MOD_W'($random(seed));
    tbl[seg][2*pair]   = lo;
    tbl[seg][2*pair+1] = hi;
    @(negedge CLK);
    wr_en   = 1'b1;
    wr_addr = ADDR_W'((seg << (IDX_W - 1)) | pair);
    wr_data = '0;
    wr_data.samples.lo = lo;
    wr_data.samples.hi = hi;
    @(negedge CLK);
    wr_en = 1'b0;
  endtask

  task automatic write_cycle_last(input int seg, input int last);
    @(negedge CLK);
    wr_en   = 1'b1;
    wr_addr = ADDR_W'((1 << CTL_BIT) | seg);
    wr_data = '0;
    wr_data.cfg.cycle_last = IDX_W'(last);
    model_last[seg] = last;
    model_idx[seg]  = 0;  // a new length restarts the index.
    @(negedge CLK);
    wr_en = 1'b0;
  endtask

  task automatic pulse_update(input int n);
    repeat (n) begin
      @(negedge CLK);
      update = 1'b1;
      for (int s = 0; s < SEG_N; s++) begin
        model_idx[s] = (model_idx[s] == model_last[s]) ? 0 : model_idx[s] + 1;
      end
      @(negedge CLK);
      update = 1'b0;
    end
  endtask

  task automatic send_frame(input logic sel, input logic stp);
    logic [MOD_W-1:0] smp;
    logic [INT_W-1:0] val;
    if (!stp) begin
      cur_idx = model_idx[sel];
      cur_seg = int'(sel);
    end
    smp = tbl[cur_seg][cur_idx];
    @(negedge CLK);
    exp_idx    = IDX_W'(cur_idx);
    exp_seg    = cur_seg[0];
    exp_stop   = stp;
    frame_seen = 1'b1;
    din_valid  = 1'b1;
    seg_sel    = sel;
    stop       = stp;
    for (int k = 0; k < N_TRANS; k++) begin
      val = INT_W'($random(seed));
      intensity_in = val;
      exp_q.push_back(OUT_W'(val) * OUT_W'(smp));
      refresh_head();
      @(negedge CLK);
      din_valid = 1'b0;
    end
    // the burst has to drain before the next frame.
    do @(negedge CLK); while (dout_valid !== 1'b1);
    do @(negedge CLK); while (dout_valid === 1'b1);
  endtask

  always @(posedge CLK) begin
    if (dout_valid === 1'b1 && exp_q.size() > 0) begin
      void'(exp_q.pop_front());
      refresh_head();
    end
  end

  always @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      run_len <= 0;
    end else if (dout_valid) begin
      run_len <= run_len + 1;
    end else begin
      run_len <= 0;
    end
  end

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
      $display("Finished with errors");
      $fatal(1, "timeout");
    end
  end

  a_product: assert property (@(posedge CLK) disable iff (!rst_n)
    dout_valid && exp_cnt > 0 |-> intensity_out == exp_head)
  else begin
    $display("MISMATCH intensity_out: got 0x%h, expected 0x%h",
             $sampled(intensity_out), $sampled(exp_head));
    $display("Finished with errors");
    $fatal(1, "product check");
  end

  a_no_extra: assert property (@(posedge CLK) disable iff (!rst_n)
    dout_valid |-> exp_cnt > 0)
  else begin
    $display("dout_valid was high with no product left to expect");
    $display("Finished with errors");
    $fatal(1, "extra output");
  end

  a_burst_len: assert property (@(posedge CLK) disable iff (!rst_n)
    !dout_valid && run_len != 0 |-> run_len == N_TRANS)
  else begin
    $display("MISMATCH dout_valid burst length: got 0x%h, expected 0x%h",
             $sampled(run_len), N_TRANS);
    $display("Finished with errors");
    $fatal(1, "burst length");
  end

  a_dbg_idx: assert property (@(posedge CLK) disable iff (!rst_n)
    din_valid |=> dbg_idx == exp_idx)
  else begin
    $display("MISMATCH dbg_idx: got 0x%h, expected 0x%h", $sampled(dbg_idx), $sampled(exp_idx));
    $display("Finished with errors");
    $fatal(1, "dbg_idx");
  end

  a_dbg_segment: assert property (@(posedge CLK) disable iff (!rst_n)
    din_valid |=> dbg_segment == exp_seg)
  else begin
    $display("MISMATCH dbg_segment: got 0x%h, expected 0x%h",
             $sampled(dbg_segment), $sampled(exp_seg));
    $display("Finished with errors");
    $fatal(1, "dbg_segment");
  end

  a_dbg_stop: assert property (@(posedge CLK) disable iff (!rst_n)
    din_valid |=> dbg_stop == exp_stop)
  else begin
    $display("MISMATCH dbg_stop: got 0x%h, expected 0x%h", $sampled(dbg_stop), $sampled(exp_stop));
    $display("Finished with errors");
    $fatal(1, "dbg_stop");
  end

  a_reset_quiet: assert property (@(posedge CLK) disable iff (!rst_n)
    !frame_seen |-> !dout_valid)
  else begin
    $display("dout_valid went high before the first frame was sent");
    $display("Finished with errors");
    $fatal(1, "early output");
  end

  initial begin
    seed         = 41;
    cycles       = 0;
    rst_n        = 1'b0;
    wr_en        = 1'b0;
    wr_addr      = '0;
    wr_data      = '0;
    update       = 1'b0;
    din_valid    = 1'b0;
    intensity_in = '0;
    seg_sel      = 1'b0;
    stop         = 1'b0;
    frame_seen   = 1'b0;
    exp_idx      = '0;
    exp_seg      = 1'b0;
    exp_stop     = 1'b0;
    cur_idx      = 0;
    cur_seg      = 0;
    for (int s = 0; s < SEG_N; s++) begin
      model_last[s] = 2**IDX_W - 1;
      model_idx[s]  = 0;
    end
    refresh_head();
    write_pair(0, 0);  // entry 0 is read as soon as reset lifts.
    @(negedge CLK);
    rst_n = 1'b1;
    for (int s = 0; s < SEG_N; s++) begin
      for (int p = 0; p < TBL_LEN / 2; p++) begin
        write_pair(s, p);
      end
    end
    send_frame(1'b0, 1'b0);  // no update yet, index 0.
    write_cycle_last(0, 9);
    write_cycle_last(1, 13);
    pulse_update(3);
    send_frame(1'b1, 1'b0);
    pulse_update(4);
    send_frame(1'b0, 1'b0);
    pulse_update(5);
    send_frame(1'b1, 1'b1);  // stopped, keeps the last index and segment.
    send_frame(1'b0, 1'b0);  // segment 0 wrapped through 0.
    pulse_update(10);        // one full segment 0 cycle
    send_frame(1'b0, 1'b0);
    pulse_update(8);
    send_frame(1'b0, 1'b0);  // lands on 0.
    send_frame(1'b1, 1'b0);
    repeat (4) @(negedge CLK);
    if (exp_q.size() == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      $display("%0d expected products never came out", exp_q.size());
      $display("Finished with errors");
      $fatal(1, "missing output");
    end
  end

endmodule

`default_nettype wire
